/* hdl/esp_link_pkg.sv */
package esp_link_pkg;

  // one byte on the esp link
  typedef logic [7:0] byte_t;

  // command codes understood by the parser
  // numbering matches the esp firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_led          = 8'd26,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31,
    set_esp_status   = 8'd32,
    set_printer_en   = 8'd33
  } cmd_code_e;

  // magic byte so the esp can detect the fpga
  localparam byte_t COOKIE = 8'hAF;

  // firmware version, packed as {major, minor}
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // flash control register layout
  // bit 7 is chip select, active high inside the register
  localparam int FLASH_CS_BIT = 7;

endpackage

/* hdl/esp_cmd_if.sv */
interface esp_cmd_if;
  import esp_link_pkg::*;

  // one-cycle command strobe
  logic      action;
  cmd_code_e cmd;
  byte_t     param;

  // flash shift register, read back by get_spi_data
  byte_t     rx_data;

  modport parser (
    output action,
    output cmd,
    output param,
    input  rx_data
  );

  modport target (
    input  action,
    input  cmd,
    input  param,
    output rx_data
  );

endinterface

/* hdl/esp_spi_slave.sv */
module esp_spi_slave (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  logic                cs_fpga,
  input  logic                sck,
  input  logic                mosi,
  input  esp_link_pkg::byte_t tx_byte,
  output logic                miso,
  output esp_link_pkg::byte_t rx_byte,
  output logic                byte_valid
);
  import esp_link_pkg::*;

  logic [2:0] sck_r;
  logic [1:0] cs_r;
  logic [1:0] mosi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      tx_shift;

  // pin synchronizers, cs comes up inactive
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r  <= 3'b000;
      cs_r   <= 2'b11;
      mosi_r <= 2'b00;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[0], cs_fpga};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[1];

  // bit counter and byte strobe
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7)
          byte_valid <= 1'b1;
      end
    end
  end

  // receive and transmit shifters, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_byte <= {rx_byte[6:0], mosi_r[1]};
    if (bit_cnt == 3'd0)
      tx_shift <= tx_byte;
    else if (cs_active && sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  assign miso = cs_active ? tx_shift[7] : 1'bz;

  a_byte_valid_pulse: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) byte_valid |=> !byte_valid
  );

endmodule

/* hdl/esp_cmd_parser.sv */
module esp_cmd_parser (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  esp_link_pkg::byte_t rx_byte,
  input  logic                byte_valid,
  output esp_link_pkg::byte_t tx_byte,
  output logic                spi_error,
  esp_cmd_if.parser           cmd
);
  import esp_link_pkg::*;

  typedef enum logic {
    idle,
    read_param
  } state_t;

  state_t    state;
  cmd_code_e code;
  logic      known;
  logic      needs_param;

  // decode the incoming byte as a command code
  always_comb begin
    code        = cmd_code_e'(rx_byte);
    known       = 1'b1;
    needs_param = 1'b0;
    case (code)
      get_cookie,
      get_version,
      get_spi_data: begin
        needs_param = 1'b0;
      end
      set_led,
      set_spi_ctrl_reg,
      set_spi_data,
      set_esp_status,
      set_printer_en: begin
        needs_param = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  // command fsm and action strobe
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state      <= idle;
      cmd.action <= 1'b0;
      cmd.cmd    <= get_cookie;
      spi_error  <= 1'b0;
    end else begin
      cmd.action <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            if (!known) begin
              // sticky until reset
              spi_error <= 1'b1;
            end else begin
              cmd.cmd <= code;
              if (needs_param)
                state <= read_param;
              else
                cmd.action <= 1'b1;
            end
          end
          read_param: begin
            cmd.action <= 1'b1;
            state      <= idle;
          end
          default: begin
            state <= idle;
          end
        endcase
      end
    end
  end

  // parameter capture and response byte
  always_ff @(posedge clk) begin
    if (byte_valid && state == read_param)
      cmd.param <= rx_byte;
    if (cmd.action) begin
      case (cmd.cmd)
        get_cookie:   tx_byte <= COOKIE;
        get_version:  tx_byte <= {VERSION_MAJOR, VERSION_MINOR};
        get_spi_data: tx_byte <= cmd.rx_data;
        // other commands leave the last response in place
        default:      tx_byte <= tx_byte;
      endcase
    end
  end

  a_action_after_byte: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) cmd.action |-> $past(byte_valid)
  );

endmodule

/* hdl/flash_spi_master.sv */
module flash_spi_master #(
  parameter int FLASH_HALF_LOG2 = 3
) (
  input  logic      clk,
  input  logic      cass_out_sel_n,
  esp_cmd_if.target cmd,
  input  logic      flash_spi_so,
  output logic      flash_spi_cs_n,
  output logic      flash_spi_clk,
  output logic      flash_spi_si
);
  import esp_link_pkg::*;

  // busy bit on top of 8 bits times one full flash clock period
  localparam int CNT_W = FLASH_HALF_LOG2 + 5;
  localparam logic [CNT_W-1:0] CNT_START = 1 << (CNT_W - 1);
  localparam logic [FLASH_HALF_LOG2:0] MID_PHASE = 1 << FLASH_HALF_LOG2;

  byte_t                  ctrl_reg;
  byte_t                  shift_reg;
  logic [CNT_W-1:0]       bit_cnt;
  logic [FLASH_HALF_LOG2:0] phase;
  logic                   busy;
  logic                   start;
  logic                   sdo;

  assign busy  = bit_cnt[CNT_W-1];
  assign phase = bit_cnt[FLASH_HALF_LOG2:0];
  // no back-pressure, a request during a transfer is dropped
  assign start = cmd.action && (cmd.cmd == set_spi_data) && !busy;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl_reg <= '0;
      bit_cnt  <= '0;
      sdo      <= 1'b0;
    end else begin
      if (cmd.action && cmd.cmd == set_spi_ctrl_reg)
        ctrl_reg <= cmd.param;
      if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // drive next bit while the clock is low
        if (phase == '0)
          sdo <= shift_reg[7];
      end else if (start) begin
        bit_cnt <= CNT_START;
      end
    end
  end

  // sample the flash output at mid-period, clock high
  always_ff @(posedge clk) begin
    if (busy) begin
      if (phase == MID_PHASE)
        shift_reg <= {shift_reg[6:0], flash_spi_so};
    end else if (start) begin
      shift_reg <= cmd.param;
    end
  end

  assign cmd.rx_data    = shift_reg;
  assign flash_spi_cs_n = ~ctrl_reg[FLASH_CS_BIT];
  assign flash_spi_clk  = bit_cnt[FLASH_HALF_LOG2];
  assign flash_spi_si   = sdo;

  a_clk_idle_low: assert property (
    @(posedge clk) disable iff (!cass_out_sel_n) (!busy && !start) |=> !flash_spi_clk
  );

endmodule

/* hdl/board_status_regs.sv */
module board_status_regs (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  esp_cmd_if.target           cmd,
  output logic                led_red,
  output logic                led_green,
  output logic                led_blue,
  output esp_link_pkg::byte_t esp_status,
  output logic                printer_en
);
  import esp_link_pkg::*;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red    <= 1'b0;
      led_green  <= 1'b0;
      led_blue   <= 1'b0;
      esp_status <= '0;
      // printer port is on until the esp says otherwise
      printer_en <= 1'b1;
    end else if (cmd.action) begin
      case (cmd.cmd)
        set_led: begin
          led_red   <= cmd.param[0];
          led_green <= cmd.param[1];
          led_blue  <= cmd.param[2];
        end
        set_esp_status: begin
          esp_status <= cmd.param;
        end
        set_printer_en: begin
          printer_en <= cmd.param[0];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

/* hdl/esp_bridge_top.sv */
module esp_bridge_top #(
  parameter int FLASH_HALF_LOG2 = 3
) (
  input  logic                clk,
  input  logic                cass_out_sel_n,
  input  logic                cs_fpga,
  input  logic                sck,
  input  logic                mosi,
  input  logic                flash_spi_so,
  output logic                miso,
  output logic                led_red,
  output logic                led_green,
  output logic                led_blue,
  output esp_link_pkg::byte_t esp_status,
  output logic                printer_en,
  output logic                spi_error,
  output logic                flash_spi_cs_n,
  output logic                flash_spi_clk,
  output logic                flash_spi_si
);
  import esp_link_pkg::*;

  byte_t rx_byte;
  byte_t tx_byte;
  logic  byte_valid;

  // decoded commands toward the targets
  esp_cmd_if cmd_bus ();

  esp_spi_slave esp_spi_slave_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_fpga        (cs_fpga),
    .sck            (sck),
    .mosi           (mosi),
    .tx_byte        (tx_byte),
    .miso           (miso),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid)
  );

  esp_cmd_parser esp_cmd_parser_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid),
    .tx_byte        (tx_byte),
    .spi_error      (spi_error),
    .cmd            (cmd_bus.parser)
  );

  flash_spi_master #(
    .FLASH_HALF_LOG2 (FLASH_HALF_LOG2)
  ) flash_spi_master_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd_bus.target),
    .flash_spi_so   (flash_spi_so),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si)
  );

  board_status_regs board_status_regs_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd_bus.target),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .printer_en     (printer_en)
  );

endmodule

/* sim/tb_esp_bridge.sv */
module tb_esp_bridge;
  import esp_link_pkg::*;

  // esp side timing in clk cycles
  localparam int SCK_HALF      = 8;
  localparam int CS_GAP        = 6;
  localparam int PIN_TIMEOUT   = 40;
  localparam int IDLE_CYCLES   = 24;
  localparam int FLASH_TIMEOUT = 600;
  localparam logic [31:0] SEED = 32'd17963;

  logic  clk;
  logic  cass_out_sel_n;
  logic  cs_fpga;
  logic  sck;
  logic  mosi;
  wire   miso;
  logic  led_red;
  logic  led_green;
  logic  led_blue;
  byte_t esp_status;
  logic  printer_en;
  logic  spi_error;
  logic  flash_spi_cs_n;
  logic  flash_spi_clk;
  logic  flash_spi_si;
  wire   flash_spi_so;

  int          errors;
  int          checks;
  logic [31:0] rng_state;
  int          flash_edges = 0;
  byte_t       flash_capture;

  // flash data loops straight back
  assign flash_spi_so = flash_spi_si;

  esp_bridge_top #(
    .FLASH_HALF_LOG2 (3)
  ) esp_bridge_top_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cs_fpga        (cs_fpga),
    .sck            (sck),
    .mosi           (mosi),
    .flash_spi_so   (flash_spi_so),
    .miso           (miso),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .esp_status     (esp_status),
    .printer_en     (printer_en),
    .spi_error      (spi_error),
    .flash_spi_cs_n (flash_spi_cs_n),
    .flash_spi_clk  (flash_spi_clk),
    .flash_spi_si   (flash_spi_si)
  );

  always #10 clk = ~clk;

  // flash bus as the flash chip sees it, msb first
  always @(posedge flash_spi_clk) begin
    flash_capture = {flash_capture[6:0], flash_spi_si};
    flash_edges++;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // the dummy byte is parsed as a command too,
  // so it is kept to the reads without a parameter
  function automatic byte_t pick_filler();
    rng_state = next_random(rng_state);
    case (rng_state % 3)
      0:       return 8'h00;
      1:       return 8'h0F;
      default: return 8'h1F;
    endcase
  endfunction

  function automatic logic is_pin(input string kind);
    return (kind == "cs_n") || (kind == "leds") || (kind == "status") ||
           (kind == "prn_en") || (kind == "err");
  endfunction

  function automatic byte_t pin_value(input string kind);
    if (kind == "cs_n")
      return {7'd0, flash_spi_cs_n};
    else if (kind == "leds")
      return {5'd0, led_blue, led_green, led_red};
    else if (kind == "status")
      return esp_status;
    else if (kind == "prn_en")
      return {7'd0, printer_en};
    else
      return {7'd0, spi_error};
  endfunction

  // wait n rising edges, then step past the edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  // one byte each way, msb first, miso sampled at the rising sck
  task automatic exchange_byte(input byte_t tx, output byte_t rx);
    int i;
    rx = 8'h00;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      tick(SCK_HALF);
      rx = {rx[6:0], miso};
      sck = 1'b1;
      tick(SCK_HALF);
      sck = 1'b0;
    end
  endtask

  task automatic run_transaction(input int cnt, input byte_t b0, input byte_t b1,
                                 output byte_t rx);
    rx = 8'h00;
    cs_fpga = 1'b0;
    if (cnt > 0)
      exchange_byte(b0, rx);
    if (cnt > 1)
      exchange_byte(b1, rx);
    cs_fpga = 1'b1;
    tick(CS_GAP);
  endtask

  task automatic check_readback(input string name, input byte_t exp);
    byte_t act;
    byte_t filler;
    filler = pick_filler();
    run_transaction(1, filler, 8'h00, act);
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_pin(input string name, input string kind, input byte_t exp);
    int    waited;
    byte_t act;
    waited = 0;
    act = pin_value(kind);
    while (act !== exp && waited < PIN_TIMEOUT) begin
      tick(1);
      waited++;
      act = pin_value(kind);
    end
    checks++;
    if (act !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // idle once the flash clock has been low for longer than a bit period,
  // then the flash must have seen eight clocks carrying the written byte
  task automatic check_flash_transfer(input string name, input byte_t exp,
                                      input int edges_before);
    int waited;
    int low_run;
    int pulses;
    waited = 0;
    low_run = 0;
    while (low_run < IDLE_CYCLES && waited < FLASH_TIMEOUT) begin
      tick(1);
      waited++;
      if (flash_spi_clk === 1'b0)
        low_run++;
      else
        low_run = 0;
    end
    checks++;
    if (low_run < IDLE_CYCLES) begin
      $display("%s: flash clock still running after %0d cycles", name, FLASH_TIMEOUT);
      errors++;
    end
    pulses = flash_edges - edges_before;
    checks++;
    if (pulses != 8) begin
      $display("%s: flash clock gave %0d pulses instead of 8", name, pulses);
      errors++;
    end else if (flash_capture !== exp) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, flash_capture);
      errors++;
    end
  endtask

  task automatic run_step(input string name, input int cnt, input byte_t b0,
                          input byte_t b1, input string kind, input byte_t exp);
    byte_t rx;
    int    edges_before;
    edges_before = flash_edges;
    if (cnt > 0)
      run_transaction(cnt, b0, b1, rx);
    if (kind == "rd") begin
      check_readback(name, exp);
    end else if (kind == "fl_idle") begin
      check_flash_transfer(name, b1, edges_before);
    end else if (is_pin(kind)) begin
      check_pin(name, kind, exp);
    end else begin
      $display("%s: unknown check %s in stim file", name, kind);
      errors++;
    end
  endtask

  initial begin
    int    fd;
    int    nf;
    int    cnt;
    string line;
    string name;
    string kind;
    byte_t b0;
    byte_t b1;
    byte_t exp;
    clk = 1'b0;
    cass_out_sel_n = 1'b0;
    cs_fpga = 1'b1;
    sck = 1'b0;
    mosi = 1'b0;
    errors = 0;
    checks = 0;
    rng_state = SEED;
    repeat (16) @(posedge clk);
    #2;
    cass_out_sel_n = 1'b1;
    tick(2);

    fd = $fopen("sim/esp_link_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/esp_link_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        nf = $fgets(line, fd);
        // skip comment lines
        if (nf > 0 && line.getc(0) != "#") begin
          nf = $sscanf(line, "%s %d %h %h %s %h", name, cnt, b0, b1, kind, exp);
          if (nf == 6) begin
            run_step(name, cnt, b0, b1, kind, exp);
          end else if (nf > 0) begin
            $display("malformed stim line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sim/esp_link_stim.txt */
# columns: test name, byte count (0..2), byte 0, byte 1, check, expected value (all hex)
# check is rd (read back on the next transfer), fl_idle, or a pin: cs_n leds status prn_en err
rst_cs_n         0 00 00 cs_n    01
rst_leds         0 00 00 leds    00
rst_status       0 00 00 status  00
rst_err          0 00 00 err     00
rst_prn_en       0 00 00 prn_en  01
cookie           1 00 00 rd      af
version          1 0f 00 rd      03
led_red_blue     2 1a 05 leds    05
led_all          2 1a 07 leds    07
led_green        2 1a 02 leds    02
esp_status       2 20 9c status  9c
printer_off      2 21 00 prn_en  00
printer_on       2 21 01 prn_en  01
printer_off_2    2 21 00 prn_en  00
flash_cs_on      2 1d 80 cs_n    00
spi_wr_a5        2 1e a5 fl_idle 00
spi_rd_a5        1 1f 00 rd      a5
spi_wr_3c        2 1e 3c fl_idle 00
spi_rd_3c        1 1f 00 rd      3c
flash_cs_off     2 1d 00 cs_n    01
err_clean        0 00 00 err     00
bad_code         1 7e 00 err     01
cookie_after_err 1 00 00 rd      af
version_after    1 0f 00 rd      03
err_sticky       0 00 00 err     01

/* src.f */
hdl/esp_link_pkg.sv
hdl/esp_cmd_if.sv
hdl/esp_spi_slave.sv
hdl/esp_cmd_parser.sv
hdl/flash_spi_master.sv
hdl/board_status_regs.sv
hdl/esp_bridge_top.sv
sim/tb_esp_bridge.sv

/* Bender.yml */
package:
  name: esp_bridge

sources:
  - hdl/esp_link_pkg.sv
  - hdl/esp_cmd_if.sv
  - hdl/esp_spi_slave.sv
  - hdl/esp_cmd_parser.sv
  - hdl/flash_spi_master.sv
  - hdl/board_status_regs.sv
  - hdl/esp_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_esp_bridge.sv
